/* verilog/fifo_config.svh */
// Sizing macros for the byte FIFO
// Depth, pointer and occupancy widths, event counter width
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Number of storage entries
`define FIFO_DEPTH 16
// Storage index width, log2 of the depth
`define FIFO_PTR_W 4
// Occupancy width, must hold the value FIFO_DEPTH itself
`define FIFO_COUNT_W 5
// Width of the drop and delivery counters
`define EVT_CNT_W 16

`endif

/* verilog/fifo_pkg.sv */
// Shared types for the byte buffer
// Byte, pointer, occupancy and event counter vectors
`include "fifo_config.svh"

package fifo_pkg;

  // One payload byte
  typedef logic [7:0] data_t;

  // Index into the storage array, wraps at the depth
  typedef logic [`FIFO_PTR_W-1:0] ptr_t;

  // Number of stored bytes, 0 up to the depth
  typedef logic [`FIFO_COUNT_W-1:0] count_t;

  // Saturating event counter
  typedef logic [`EVT_CNT_W-1:0] evt_cnt_t;

endpackage

/* verilog/byte_ingress.sv */
// Producer side of the byte buffer
// Gates strobes against full and counts dropped bytes
`timescale 1ns/1ps

module byte_ingress
  import fifo_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  data_t    in_data,
  input  logic     full,
  output logic     wr_en,
  output data_t    din,
  output evt_cnt_t drop_count
);

  // Counter ceiling, all ones
  localparam evt_cnt_t EVT_MAX = '1;

  // Strobe lost because the FIFO has no room
  logic drop;

  // Write in the same cycle as the strobe
  assign wr_en = in_valid && !full;
  assign din   = in_data;

  assign drop = in_valid && full;

  // Drop counter holds at its maximum
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      drop_count <= '0;
    end else if (drop && (drop_count != EVT_MAX)) begin
      drop_count <= drop_count + evt_cnt_t'(1);
    end
  end

  // Never push into a full FIFO
  assert property (@(posedge clk) disable iff (rst) full |-> !wr_en)
    else $error("wr_en high while full");

endmodule

/* verilog/fifo.sv */
// Synchronous byte FIFO core
// Storage array, wrapping pointers, occupancy count, flags, registered read data
`timescale 1ns/1ps
`include "fifo_config.svh"

module fifo
  import fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  data_t  din,
  input  logic   wr_en,
  input  logic   rd_en,
  output data_t  dout,
  output logic   full,
  output logic   empty,
  output ptr_t   wr_ptr,
  output ptr_t   rd_ptr,
  output count_t count
);

  // Occupancy at which the FIFO is full
  localparam count_t DEPTH_C = count_t'(`FIFO_DEPTH);

  // Byte storage
  data_t mem [`FIFO_DEPTH];

  // Operations that actually take effect
  logic do_wr;
  logic do_rd;

  // Overflow and underflow guards
  // Other users may drive the ports without looking at the flags
  assign do_wr = wr_en && (count != DEPTH_C);
  assign do_rd = rd_en && (count != '0);

  // Flags follow the registered count
  assign full  = (count == DEPTH_C);
  assign empty = (count == '0);

  // Pointers and occupancy
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own at the depth
      if (do_wr) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      // Read and write together leave the count as it is
      case ({do_wr, do_rd})
        2'b10:   count <= count + count_t'(1);
        2'b01:   count <= count - count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Read port, dout holds between reads
  // A slot being read is never the one being written, except when empty,
  // and then no read takes place
  always_ff @(posedge clk) begin
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

/* verilog/fifo_asserts.sv */
// Bound checker for the FIFO core
// Golden occupancy model, byte order queue, flag and step assertions, coverage
`timescale 1ns/1ps
`include "fifo_config.svh"

module fifo_asserts
  import fifo_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input data_t  din,
  input logic   wr_en,
  input logic   rd_en,
  input data_t  dout,
  input logic   full,
  input logic   empty,
  input ptr_t   wr_ptr,
  input ptr_t   rd_ptr,
  input count_t count
);

  localparam count_t DEPTH_C = count_t'(`FIFO_DEPTH);
  localparam ptr_t   LAST_PTR = ptr_t'(`FIFO_DEPTH - 1);

  // Model occupancy, built only from the ports, never from the flags
  count_t m_count;
  // Writes and reads the model allows
  logic   mw;
  logic   mr;

  assign mw = !rst && wr_en && (m_count != DEPTH_C);
  assign mr = !rst && rd_en && (m_count != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      m_count <= '0;
    end else begin
      m_count <= m_count + count_t'(mw) - count_t'(mr);
    end
  end

  // Reset values, sampled while reset is held
  always @(posedge clk) begin
    if (rst) begin
      assert (wr_ptr == '0 && rd_ptr == '0 && count == '0)
        else $error("reset state wrong: wr_ptr=%0d rd_ptr=%0d count=%0d",
                    wr_ptr, rd_ptr, count);
      assert (empty && !full)
        else $error("reset flags wrong: empty=%0b full=%0b", empty, full);
    end
  end

  // Flags and count against the model
  assert property (@(posedge clk) disable iff (rst) full == (m_count == DEPTH_C))
    else $error("full mismatch: model %0d full %0b", m_count, full);
  assert property (@(posedge clk) disable iff (rst) empty == (m_count == '0))
    else $error("empty mismatch: model %0d empty %0b", m_count, empty);
  assert property (@(posedge clk) disable iff (rst) count == m_count)
    else $error("count %0d differs from model %0d", count, m_count);

  // Count steps
  assert property (@(posedge clk) disable iff (rst)
                   mw && !mr |=> count == count_t'($past(count) + count_t'(1)))
    else $error("count did not rise on a write");
  assert property (@(posedge clk) disable iff (rst)
                   mr && !mw |=> count == count_t'($past(count) - count_t'(1)))
    else $error("count did not fall on a read");
  assert property (@(posedge clk) disable iff (rst) mw == mr |=> $stable(count))
    else $error("count moved without a net operation");

  // Pointer steps, wrapping at the depth
  assert property (@(posedge clk) disable iff (rst)
                   mw |=> wr_ptr == ptr_t'($past(wr_ptr) + ptr_t'(1)))
    else $error("wr_ptr did not advance on a write");
  assert property (@(posedge clk) disable iff (rst) !mw |=> $stable(wr_ptr))
    else $error("wr_ptr moved without a write");
  assert property (@(posedge clk) disable iff (rst)
                   mr |=> rd_ptr == ptr_t'($past(rd_ptr) + ptr_t'(1)))
    else $error("rd_ptr did not advance on a read");
  assert property (@(posedge clk) disable iff (rst) !mr |=> $stable(rd_ptr))
    else $error("rd_ptr moved without a read");

  // Read data register holds without a read
  assert property (@(posedge clk) disable iff (rst) !mr |=> dout === $past(dout))
    else $error("dout changed without a read");

  // Blocked operations leave the state untouched
  assert property (@(posedge clk) disable iff (rst)
                   (m_count == DEPTH_C) && wr_en && !rd_en |=>
                   $stable(wr_ptr) && $stable(count))
    else $error("write at full changed the state");
  assert property (@(posedge clk) disable iff (rst)
                   (m_count == '0) && rd_en && !wr_en |=>
                   $stable(rd_ptr) && $stable(count))
    else $error("read at empty changed the state");

  // Byte order model
  data_t model_q [$];
  // Byte expected on dout after the last read edge
  data_t exp_byte;
  logic  exp_vld;

  always @(posedge clk or posedge rst) begin : order_model
    data_t head;
    if (rst) begin
      model_q.delete();
      exp_vld <= 1'b0;
    end else begin
      exp_vld <= mr;
      // Pop before push, so a simultaneous write lands behind the head
      if (mr) begin
        head = model_q.pop_front();
        exp_byte <= head;
      end
      if (mw) begin
        model_q.push_back(din);
      end
    end
  end

  // dout carries the oldest stored byte after each read
  assert property (@(posedge clk) disable iff (rst) exp_vld |-> dout == exp_byte)
    else $error("data order: got %02h expected %02h", dout, exp_byte);

  // Corner cases reached
  cover property (@(posedge clk) disable iff (rst) m_count == DEPTH_C);
  cover property (@(posedge clk) disable iff (rst) $fell(m_count != '0));
  cover property (@(posedge clk) disable iff (rst) mw && mr);
  // Pointer wraps
  cover property (@(posedge clk) disable iff (rst)
                  mw && (wr_ptr == LAST_PTR) ##1 wr_ptr == '0);
  cover property (@(posedge clk) disable iff (rst)
                  mr && (rd_ptr == LAST_PTR) ##1 rd_ptr == '0);

endmodule

/* verilog/byte_egress.sv */
// Consumer side of the byte buffer
// Reads while ready, marks delivered bytes, counts them
`timescale 1ns/1ps

module byte_egress
  import fifo_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     out_ready,
  input  logic     empty,
  input  data_t    dout,
  output logic     rd_en,
  output logic     out_valid,
  output data_t    out_data,
  output evt_cnt_t out_count
);

  // Counter ceiling, all ones
  localparam evt_cnt_t EVT_MAX = '1;

  // Pull a byte whenever the consumer wants one and the FIFO has one
  assign rd_en = out_ready && !empty;

  // dout is already registered in the FIFO
  assign out_data = dout;

  // Valid pulse in the cycle after each read edge
  // Back-to-back reads give a steady level
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= rd_en;
    end
  end

  // Delivered byte counter, saturating
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_count <= '0;
    end else if (rd_en && (out_count != EVT_MAX)) begin
      out_count <= out_count + evt_cnt_t'(1);
    end
  end

  // Each valid cycle comes from a read one edge earlier
  assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(rd_en))
    else $error("out_valid without a preceding read");

endmodule

/* verilog/byte_buffer_top.sv */
// Byte buffer top level
// Ingress, FIFO core and egress, with the FIFO checker bound in
`timescale 1ns/1ps

module byte_buffer_top
  import fifo_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  data_t    in_data,
  input  logic     out_ready,
  output logic     out_valid,
  output data_t    out_data,
  output logic     full,
  output logic     empty,
  output count_t   level,
  output evt_cnt_t drop_count,
  output evt_cnt_t out_count
);

  // Ingress to FIFO
  logic  wr_en;
  data_t din;
  // FIFO to egress
  logic  rd_en;
  data_t dout;

  byte_ingress byte_ingress_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .full       (full),
    .wr_en      (wr_en),
    .din        (din),
    .drop_count (drop_count)
  );

  // Pointers are left open here and observed by the bound checker
  fifo fifo_inst (
    .clk    (clk),
    .rst    (rst),
    .din    (din),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .dout   (dout),
    .full   (full),
    .empty  (empty),
    .wr_ptr (),
    .rd_ptr (),
    .count  (level)
  );

  byte_egress byte_egress_inst (
    .clk       (clk),
    .rst       (rst),
    .out_ready (out_ready),
    .empty     (empty),
    .dout      (dout),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_count (out_count)
  );

  // Checker attached inside every fifo instance
  bind fifo fifo_asserts fifo_asserts_inst (
    .clk    (clk),
    .rst    (rst),
    .din    (din),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .dout   (dout),
    .full   (full),
    .empty  (empty),
    .wr_ptr (wr_ptr),
    .rd_ptr (rd_ptr),
    .count  (count)
  );

endmodule

/* dv/byte_buffer_tb.sv */
// Testbench for the byte buffer
// Stimulus table, queue reference model, compare tasks, cycle limit
`timescale 1ns/1ps
`include "fifo_config.svh"

module byte_buffer_tb
  import fifo_pkg::*;
();

  // Strobe patterns of a table row
  localparam logic [1:0] IDLE   = 2'd0;
  localparam logic [1:0] EVERY  = 2'd1;
  localparam logic [1:0] GAPPED = 2'd2;
  localparam int NUM_ROWS = 10;
  localparam int MARGIN   = 50;

  // One stimulus row, applied reps times
  typedef struct packed {
    logic [1:0]  strobe;
    logic        lfsr_data;
    data_t       in_data;
    logic        out_ready;
    logic [15:0] reps;
  } row_t;

  logic     clk;
  logic     rst;
  logic     in_valid;
  data_t    in_data;
  logic     out_ready;
  logic     out_valid;
  data_t    out_data;
  logic     full;
  logic     empty;
  count_t   level;
  evt_cnt_t drop_count;
  evt_cnt_t out_count;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr;
  // Inputs that the next clock edge samples
  logic        cur_valid;
  data_t       cur_data;
  logic        cur_ready;
  // Reference model state
  data_t       model_q [$];
  logic        exp_valid;
  data_t       exp_data;
  evt_cnt_t    exp_drop;
  evt_cnt_t    exp_out;
  // Counter values when a row starts to take effect
  evt_cnt_t    out_base;
  evt_cnt_t    drop_base;
  int          pending_row;
  int          strobes;
  int          max_cycles;
  int          cycle_cnt;
  int          data_errs;
  int          level_errs;
  int          evt_errs;
  int          flag_errs;

  byte_buffer_top byte_buffer_top_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .full       (full),
    .empty      (empty),
    .level      (level),
    .drop_count (drop_count),
    .out_count  (out_count)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output data_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_level(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      level_errs++;
      $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_evt(input string name, input evt_cnt_t got, input evt_cnt_t exp);
    if (got !== exp) begin
      evt_errs++;
      $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Columns: strobe pattern, LFSR data, fixed byte, out_ready, repeat count
  task automatic load_table();
    rows[0] = '{IDLE,   1'b0, 8'h00, 1'b0, 16'd2};
    // Single byte into an empty FIFO, then let it drain
    rows[1] = '{EVERY,  1'b0, 8'ha5, 1'b1, 16'd1};
    rows[2] = '{IDLE,   1'b0, 8'h00, 1'b1, 16'd4};
    // Back-pressure, 4 strobes past the depth
    rows[3] = '{EVERY,  1'b1, 8'h00, 1'b0, 16'd20};
    rows[4] = '{IDLE,   1'b0, 8'h00, 1'b1, 16'd18};
    // Half fill, then write and read together across pointer wraps
    rows[5] = '{EVERY,  1'b1, 8'h00, 1'b0, 16'd8};
    rows[6] = '{EVERY,  1'b1, 8'h00, 1'b1, 16'd40};
    rows[7] = '{IDLE,   1'b0, 8'h00, 1'b1, 16'd12};
    // 100 strobes with random gaps
    rows[8] = '{GAPPED, 1'b1, 8'h00, 1'b1, 16'd100};
    rows[9] = '{IDLE,   1'b0, 8'h00, 1'b1, 16'd6};
  endtask

  function automatic int cycle_budget();
    int total;
    total = 5 + MARGIN;
    for (int i = 0; i < NUM_ROWS; i++) begin
      // A gapped strobe takes up to 4 cycles
      total += (rows[i].strobe == GAPPED) ? 4 * int'(rows[i].reps) : int'(rows[i].reps);
    end
    return total;
  endfunction

  // Model of one clock edge with the inputs held before it
  task automatic apply_edge();
    logic at_full;
    logic at_empty;
    at_full  = (model_q.size() == `FIFO_DEPTH);
    at_empty = (model_q.size() == 0);
    // Read pops first, a write in the same edge lands behind the head
    exp_valid = cur_ready && !at_empty;
    if (exp_valid) begin
      exp_data = model_q.pop_front();
      if (exp_out != '1) begin
        exp_out = exp_out + evt_cnt_t'(1);
      end
    end
    // Strobe at full is lost and counted
    if (cur_valid && at_full && (exp_drop != '1)) begin
      exp_drop = exp_drop + evt_cnt_t'(1);
    end
    if (cur_valid && !at_full) begin
      model_q.push_back(cur_data);
    end
  endtask

  task automatic check_model();
    check_level("level", level, count_t'(model_q.size()));
    check_flag("full", full, model_q.size() == `FIFO_DEPTH);
    check_flag("empty", empty, model_q.size() == 0);
    check_flag("out_valid", out_valid, exp_valid);
    check_evt("drop_count", drop_count, exp_drop);
    check_evt("out_count", out_count, exp_out);
    // Data only counts during the valid pulse
    if (exp_valid) begin
      check_data("out_data", out_data, exp_data);
    end
  endtask

  // Fixed end points, once every input of a row has reached the DUT
  task automatic row_done(input int idx);
    case (idx)
      3: begin
        check_level("level", level, count_t'(`FIFO_DEPTH));
        check_flag("full", full, 1'b1);
        check_evt("drop_count delta", drop_count - drop_base, evt_cnt_t'(4));
      end
      4: begin
        check_flag("empty", empty, 1'b1);
        check_evt("out_count delta", out_count - out_base, evt_cnt_t'(16));
      end
      6: check_level("level", level, count_t'(8));
      9: begin
        check_flag("empty", empty, 1'b1);
        // Every strobe was either delivered or dropped
        check_evt("out_count+drop_count", out_count + drop_count, evt_cnt_t'(strobes));
      end
      default: ;
    endcase
  endtask

  // Drive on the rising edge, compare at the falling edge
  task automatic cycle(input logic v, input data_t d, input logic r);
    @(posedge clk);
    apply_edge();
    in_valid  <= v;
    in_data   <= d;
    out_ready <= r;
    cur_valid = v;
    cur_data  = d;
    cur_ready = r;
    if (v) begin
      strobes++;
    end
    @(negedge clk);
    check_model();
    if (pending_row >= 0) begin
      row_done(pending_row);
      pending_row = -1;
      out_base  = exp_out;
      drop_base = exp_drop;
    end
  endtask

  initial begin : stimulus
    row_t  row;
    data_t b;
    data_t gap;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = 8'h00;
    out_ready = 1'b0;
    cur_valid = 1'b0;
    cur_data = 8'h00;
    cur_ready = 1'b0;
    exp_valid = 1'b0;
    exp_data = 8'h00;
    exp_drop = '0;
    exp_out = '0;
    out_base = '0;
    drop_base = '0;
    pending_row = -1;
    strobes = 0;
    data_errs = 0;
    level_errs = 0;
    evt_errs = 0;
    flag_errs = 0;
    lfsr = 32'h76a8;
    load_table();
    max_cycles = cycle_budget();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // State right after reset
    @(negedge clk);
    check_flag("empty", empty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("out_valid", out_valid, 1'b0);
    check_level("level", level, count_t'(0));
    check_evt("drop_count", drop_count, evt_cnt_t'(0));
    check_evt("out_count", out_count, evt_cnt_t'(0));
    for (int i = 0; i < NUM_ROWS; i++) begin
      row = rows[i];
      pending_row = i - 1;
      for (int n = 0; n < int'(row.reps); n++) begin
        if (row.strobe == GAPPED) begin
          // Idle gap of 0 to 3 cycles before each strobe
          draw_bits(2, gap);
          repeat (int'(gap)) cycle(1'b0, 8'h00, row.out_ready);
        end
        if (row.strobe == IDLE) begin
          b = 8'h00;
        end else if (row.lfsr_data) begin
          draw_bits(8, b);
        end else begin
          b = row.in_data;
        end
        cycle(row.strobe != IDLE, b, row.out_ready);
      end
    end
    // One more edge so the last row takes full effect
    pending_row = NUM_ROWS - 1;
    cycle(1'b0, 8'h00, 1'b1);
    $display("Errors: data %0d, level %0d, counter %0d, flag %0d, total %0d",
             data_errs, level_errs, evt_errs, flag_errs,
             data_errs + level_errs + evt_errs + flag_errs);
    if ((data_errs + level_errs + evt_errs + flag_errs) == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Cycle limit from the table length plus a margin
  initial begin : watchdog
    cycle_cnt = 0;
    wait (max_cycles > 0);
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: stimulus still running after %0d cycles", max_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* build.f */
+incdir+verilog
verilog/fifo_pkg.sv
verilog/byte_ingress.sv
verilog/fifo.sv
verilog/fifo_asserts.sv
verilog/byte_egress.sv
verilog/byte_buffer_top.sv
dv/byte_buffer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the byte buffer simulation with Verilator
# The run passes only if the log holds the pass line

LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module byte_buffer_tb -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vbyte_buffer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
